// File: verilog/axi_id_remap_pkg.sv
/* shared widths, table size, ID and payload types and the AXI response
   encoding for the read-path ID remapper */
`default_nettype none

package axi_id_remap_pkg;

  localparam int unsigned addr_width   = 32;
  localparam int unsigned data_width   = 32;
  localparam int unsigned id_width_in  = 6;
  localparam int unsigned id_width_out = 2;

  // one slot per downstream ID
  localparam int unsigned table_size      = 4;
  localparam int unsigned max_txns_per_id = 4;
  localparam int unsigned cnt_width       = 3;

  typedef logic [addr_width-1:0]   addr_t;
  typedef logic [data_width-1:0]   data_t;
  typedef logic [id_width_in-1:0]  in_id_t;
  typedef logic [id_width_out-1:0] out_id_t;
  typedef logic [7:0]              len_t;
  typedef logic [cnt_width-1:0]    cnt_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

endpackage

`default_nettype wire

// File: verilog/ar_chan_if.sv
/* AR channel bundle with the narrow downstream ID */
`default_nettype none

interface ar_chan_if ();

  axi_id_remap_pkg::out_id_t id;
  axi_id_remap_pkg::addr_t   addr;
  axi_id_remap_pkg::len_t    len;
  logic                      valid;
  logic                      ready;

  modport source (
    output id, addr, len, valid,
    input  ready
  );

  modport sink (
    input  id, addr, len, valid,
    output ready
  );

endinterface

`default_nettype wire

// File: verilog/r_chan_if.sv
/* R channel bundle with the narrow downstream ID */
`default_nettype none

interface r_chan_if ();

  axi_id_remap_pkg::out_id_t id;
  axi_id_remap_pkg::data_t   data;
  axi_id_remap_pkg::resp_t   resp;
  logic                      last;
  logic                      valid;
  logic                      ready;

  // the downstream slave is the source of R beats
  modport source (
    output id, data, resp, last, valid,
    input  ready
  );

  modport sink (
    input  id, data, resp, last, valid,
    output ready
  );

endinterface

`default_nettype wire

// File: verilog/id_remap_table.sv
/* remap table with per-slot input ID and outstanding burst count,
   slot allocation, ID lookup and release */
`default_nettype none

module id_remap_table (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      alloc_valid_i,
  input  axi_id_remap_pkg::in_id_t  alloc_in_id_i,
  output logic                      alloc_ready_o,
  output axi_id_remap_pkg::out_id_t alloc_slot_o,
  input  axi_id_remap_pkg::out_id_t lookup_slot_i,
  output axi_id_remap_pkg::in_id_t  lookup_in_id_o,
  input  logic                      free_valid_i,
  input  axi_id_remap_pkg::out_id_t free_slot_i
);

  axi_id_remap_pkg::in_id_t  slot_id_q  [axi_id_remap_pkg::table_size];
  axi_id_remap_pkg::cnt_t    slot_cnt_q [axi_id_remap_pkg::table_size];

  logic                                    match_found;
  logic                                    free_found;
  axi_id_remap_pkg::out_id_t               match_slot;
  axi_id_remap_pkg::out_id_t               free_slot;
  logic                                    alloc_fire;
  logic [axi_id_remap_pkg::table_size-1:0] inc;
  logic [axi_id_remap_pkg::table_size-1:0] dec;

  // a slot is in use while its count is nonzero, the first free slot wins
  always_comb begin
    match_found = 1'b0;
    free_found  = 1'b0;
    match_slot  = '0;
    free_slot   = '0;
    for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
      if (slot_cnt_q[i] != '0 && slot_id_q[i] == alloc_in_id_i) begin
        match_found = 1'b1;
        match_slot  = axi_id_remap_pkg::out_id_t'(i);
      end
      if (!free_found && slot_cnt_q[i] == '0) begin
        free_found = 1'b1;
        free_slot  = axi_id_remap_pkg::out_id_t'(i);
      end
    end
  end

  // same-ID requests stay on their slot so downstream keeps them ordered
  assign alloc_slot_o  = match_found ? match_slot : free_slot;
  assign alloc_ready_o = match_found ?
      (slot_cnt_q[match_slot] != axi_id_remap_pkg::cnt_t'(axi_id_remap_pkg::max_txns_per_id)) :
      free_found;
  assign alloc_fire    = alloc_valid_i && alloc_ready_o;

  assign lookup_in_id_o = slot_id_q[lookup_slot_i];

  always_comb begin
    for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
      inc[i] = alloc_fire && (alloc_slot_o == axi_id_remap_pkg::out_id_t'(i));
      dec[i] = free_valid_i && (free_slot_i == axi_id_remap_pkg::out_id_t'(i));
    end
  end

  // an allocate and a free on the same slot cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
        slot_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
        if (inc[i] && !dec[i]) begin
          slot_cnt_q[i] <= slot_cnt_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          slot_cnt_q[i] <= slot_cnt_q[i] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      slot_id_q[alloc_slot_o] <= alloc_in_id_i;
    end
  end

  // the R stage only releases slots that the AR stage allocated
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    free_valid_i |-> slot_cnt_q[free_slot_i] != '0);

  for (genvar i = 0; i < axi_id_remap_pkg::table_size; i++) begin : g_uniq
    for (genvar j = i + 1; j < axi_id_remap_pkg::table_size; j++) begin : g_pair
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (slot_cnt_q[i] != '0 && slot_cnt_q[j] != '0) |-> slot_id_q[i] != slot_id_q[j]);
    end
  end

endmodule

`default_nettype wire

// File: verilog/ar_remap_stage.sv
/* registered AR stage that claims a table slot and sends the request
   downstream with the slot as its ID */
`default_nettype none

module ar_remap_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  axi_id_remap_pkg::in_id_t  in_ar_id_i,
  input  axi_id_remap_pkg::addr_t   in_ar_addr_i,
  input  axi_id_remap_pkg::len_t    in_ar_len_i,
  input  logic                      in_ar_valid_i,
  output logic                      in_ar_ready_o,
  output logic                      alloc_valid_o,
  output axi_id_remap_pkg::in_id_t  alloc_in_id_o,
  input  logic                      alloc_ready_i,
  input  axi_id_remap_pkg::out_id_t alloc_slot_i,
  ar_chan_if.source                 out_ar
);

  logic                      full_q;
  axi_id_remap_pkg::out_id_t id_q;
  axi_id_remap_pkg::addr_t   addr_q;
  axi_id_remap_pkg::len_t    len_q;
  logic                      space;
  logic                      in_fire;
  logic                      out_fire;

  // the buffer has room when empty or when its item leaves this cycle
  assign space    = !full_q || out_ar.ready;
  assign out_fire = full_q && out_ar.ready;

  assign alloc_valid_o = in_ar_valid_i && space;
  assign alloc_in_id_o = in_ar_id_i;
  assign in_ar_ready_o = space && alloc_ready_i;
  assign in_fire       = in_ar_valid_i && in_ar_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (out_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      id_q   <= alloc_slot_i;
      addr_q <= in_ar_addr_i;
      len_q  <= in_ar_len_i;
    end
  end

  assign out_ar.valid = full_q;
  assign out_ar.id    = id_q;
  assign out_ar.addr  = addr_q;
  assign out_ar.len   = len_q;

  // a stalled request must not change under the downstream slave
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_ar.valid && !out_ar.ready) |=>
      (out_ar.valid && $stable(out_ar.id) && $stable(out_ar.addr) && $stable(out_ar.len)));

endmodule

`default_nettype wire

// File: verilog/r_restore_stage.sv
/* registered R stage that puts the upstream ID back on each beat and
   releases the slot once a burst's last beat is handed up */
`default_nettype none

module r_restore_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  r_chan_if.sink                    out_r,
  output axi_id_remap_pkg::out_id_t lookup_slot_o,
  input  axi_id_remap_pkg::in_id_t  lookup_in_id_i,
  output logic                      free_valid_o,
  output axi_id_remap_pkg::out_id_t free_slot_o,
  output axi_id_remap_pkg::in_id_t  in_r_id_o,
  output axi_id_remap_pkg::data_t   in_r_data_o,
  output axi_id_remap_pkg::resp_t   in_r_resp_o,
  output logic                      in_r_last_o,
  output logic                      in_r_valid_o,
  input  logic                      in_r_ready_i
);

  logic                      full_q;
  axi_id_remap_pkg::out_id_t slot_q;
  axi_id_remap_pkg::in_id_t  id_q;
  axi_id_remap_pkg::data_t   data_q;
  axi_id_remap_pkg::resp_t   resp_q;
  logic                      last_q;
  logic                      in_fire;
  logic                      up_fire;

  assign out_r.ready   = !full_q || in_r_ready_i;
  assign in_fire       = out_r.valid && out_r.ready;
  assign up_fire       = full_q && in_r_ready_i;
  assign lookup_slot_o = out_r.id;

  // the slot number is kept with the beat so it can be released later
  assign free_valid_o = up_fire && last_q;
  assign free_slot_o  = slot_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (up_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      slot_q <= out_r.id;
      id_q   <= lookup_in_id_i;
      data_q <= out_r.data;
      resp_q <= out_r.resp;
      last_q <= out_r.last;
    end
  end

  assign in_r_valid_o = full_q;
  assign in_r_id_o    = id_q;
  assign in_r_data_o  = data_q;
  assign in_r_resp_o  = resp_q;
  assign in_r_last_o  = last_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (in_r_valid_o && !in_r_ready_i) |=>
      (in_r_valid_o && $stable(in_r_id_o) && $stable(in_r_data_o) && $stable(in_r_last_o)));

endmodule

`default_nettype wire

// File: verilog/axi_id_remap_ports.sv
/* read-path ID remapper with flat AR and R ports on both sides */
`default_nettype none

module axi_id_remap_ports (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  axi_id_remap_pkg::in_id_t  in_ar_id_i,
  input  axi_id_remap_pkg::addr_t   in_ar_addr_i,
  input  axi_id_remap_pkg::len_t    in_ar_len_i,
  input  logic                      in_ar_valid_i,
  output logic                      in_ar_ready_o,
  output axi_id_remap_pkg::in_id_t  in_r_id_o,
  output axi_id_remap_pkg::data_t   in_r_data_o,
  output axi_id_remap_pkg::resp_t   in_r_resp_o,
  output logic                      in_r_last_o,
  output logic                      in_r_valid_o,
  input  logic                      in_r_ready_i,

  output axi_id_remap_pkg::out_id_t out_ar_id_o,
  output axi_id_remap_pkg::addr_t   out_ar_addr_o,
  output axi_id_remap_pkg::len_t    out_ar_len_o,
  output logic                      out_ar_valid_o,
  input  logic                      out_ar_ready_i,
  input  axi_id_remap_pkg::out_id_t out_r_id_i,
  input  axi_id_remap_pkg::data_t   out_r_data_i,
  input  axi_id_remap_pkg::resp_t   out_r_resp_i,
  input  logic                      out_r_last_i,
  input  logic                      out_r_valid_i,
  output logic                      out_r_ready_o
);

  logic                      alloc_valid;
  axi_id_remap_pkg::in_id_t  alloc_in_id;
  logic                      alloc_ready;
  axi_id_remap_pkg::out_id_t alloc_slot;
  axi_id_remap_pkg::out_id_t lookup_slot;
  axi_id_remap_pkg::in_id_t  lookup_in_id;
  logic                      free_valid;
  axi_id_remap_pkg::out_id_t free_slot;

  ar_chan_if ar_out ();
  assign out_ar_id_o    = ar_out.id;
  assign out_ar_addr_o  = ar_out.addr;
  assign out_ar_len_o   = ar_out.len;
  assign out_ar_valid_o = ar_out.valid;
  assign ar_out.ready   = out_ar_ready_i;

  r_chan_if r_out ();
  assign r_out.id      = out_r_id_i;
  assign r_out.data    = out_r_data_i;
  assign r_out.resp    = out_r_resp_i;
  assign r_out.last    = out_r_last_i;
  assign r_out.valid   = out_r_valid_i;
  assign out_r_ready_o = r_out.ready;

  id_remap_table i_table (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_valid_i  (alloc_valid),
    .alloc_in_id_i  (alloc_in_id),
    .alloc_ready_o  (alloc_ready),
    .alloc_slot_o   (alloc_slot),
    .lookup_slot_i  (lookup_slot),
    .lookup_in_id_o (lookup_in_id),
    .free_valid_i   (free_valid),
    .free_slot_i    (free_slot)
  );

  ar_remap_stage i_ar_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_ar_id_i    (in_ar_id_i),
    .in_ar_addr_i  (in_ar_addr_i),
    .in_ar_len_i   (in_ar_len_i),
    .in_ar_valid_i (in_ar_valid_i),
    .in_ar_ready_o (in_ar_ready_o),
    .alloc_valid_o (alloc_valid),
    .alloc_in_id_o (alloc_in_id),
    .alloc_ready_i (alloc_ready),
    .alloc_slot_i  (alloc_slot),
    .out_ar        (ar_out)
  );

  r_restore_stage i_r_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .out_r          (r_out),
    .lookup_slot_o  (lookup_slot),
    .lookup_in_id_i (lookup_in_id),
    .free_valid_o   (free_valid),
    .free_slot_o    (free_slot),
    .in_r_id_o      (in_r_id_o),
    .in_r_data_o    (in_r_data_o),
    .in_r_resp_o    (in_r_resp_o),
    .in_r_last_o    (in_r_last_o),
    .in_r_valid_o   (in_r_valid_o),
    .in_r_ready_i   (in_r_ready_i)
  );

endmodule

`default_nettype wire

// File: bench/tb_axi_id_remap.sv
/* directed testbench for the read-path ID remapper, acting as upstream
   master on the in_ ports and downstream slave on the out_ ports */
`default_nettype none

module tb_axi_id_remap;

  localparam int wait_limit = 100;

  logic clk_i;
  logic rst_n_i;
  axi_id_remap_pkg::in_id_t  in_ar_id_i;
  axi_id_remap_pkg::addr_t   in_ar_addr_i;
  axi_id_remap_pkg::len_t    in_ar_len_i;
  logic                      in_ar_valid_i;
  logic                      in_ar_ready_o;
  axi_id_remap_pkg::in_id_t  in_r_id_o;
  axi_id_remap_pkg::data_t   in_r_data_o;
  axi_id_remap_pkg::resp_t   in_r_resp_o;
  logic                      in_r_last_o;
  logic                      in_r_valid_o;
  logic                      in_r_ready_i;
  axi_id_remap_pkg::out_id_t out_ar_id_o;
  axi_id_remap_pkg::addr_t   out_ar_addr_o;
  axi_id_remap_pkg::len_t    out_ar_len_o;
  logic                      out_ar_valid_o;
  logic                      out_ar_ready_i;
  axi_id_remap_pkg::out_id_t out_r_id_i;
  axi_id_remap_pkg::data_t   out_r_data_i;
  axi_id_remap_pkg::resp_t   out_r_resp_i;
  logic                      out_r_last_i;
  logic                      out_r_valid_i;
  logic                      out_r_ready_o;

  string       cur_test;
  int unsigned seed_val;
  // reference copy of the slot table
  int          model_id  [axi_id_remap_pkg::table_size];
  int          model_cnt [axi_id_remap_pkg::table_size];

  axi_id_remap_ports axi_id_remap_ports_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_with_failure($sformatf("mismatch in %s, %s: expected %0h, actual %0h",
                                  cur_test, what, exp, act));
    end
  endtask

  // an existing ID keeps its slot, a new ID takes the lowest free one
  function automatic int model_alloc(input int in_id);
    int slot;
    slot = -1;
    for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
      if (model_cnt[i] != 0 && model_id[i] == in_id) slot = i;
    end
    if (slot < 0) begin
      for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
        if (slot < 0 && model_cnt[i] == 0) slot = i;
      end
    end
    model_id[slot]  = in_id;
    model_cnt[slot] = model_cnt[slot] + 1;
    return slot;
  endfunction

  task automatic drive_ar(input int in_id, input axi_id_remap_pkg::addr_t addr, input int len);
    in_ar_id_i    = axi_id_remap_pkg::in_id_t'(in_id);
    in_ar_addr_i  = addr;
    in_ar_len_i   = axi_id_remap_pkg::len_t'(len);
    in_ar_valid_i = 1'b1;
  endtask

  task automatic wait_ar_accept();
    int n = 0;
    @(negedge clk_i);
    while (!in_ar_ready_o) begin
      n++;
      if (n > wait_limit) stop_with_failure("the upstream AR request was never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1 in_ar_valid_i = 1'b0;
  endtask

  task automatic take_ar(input int exp_slot, input axi_id_remap_pkg::addr_t exp_addr,
                         input int exp_len);
    int n = 0;
    out_ar_ready_i = 1'b1;
    @(negedge clk_i);
    while (!out_ar_valid_o) begin
      n++;
      if (n > wait_limit) stop_with_failure("no AR request appeared downstream");
      @(negedge clk_i);
    end
    check("out_ar_id", exp_slot, out_ar_id_o);
    check("out_ar_addr", exp_addr, out_ar_addr_o);
    check("out_ar_len", exp_len, out_ar_len_o);
    @(posedge clk_i);
    #1 out_ar_ready_i = 1'b0;
  endtask

  task automatic send_r(input int slot, input axi_id_remap_pkg::data_t data,
                        input axi_id_remap_pkg::resp_t resp, input logic last);
    int n = 0;
    out_r_id_i    = axi_id_remap_pkg::out_id_t'(slot);
    out_r_data_i  = data;
    out_r_resp_i  = resp;
    out_r_last_i  = last;
    out_r_valid_i = 1'b1;
    @(negedge clk_i);
    while (!out_r_ready_o) begin
      n++;
      if (n > wait_limit) stop_with_failure("the downstream R beat was never accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1 out_r_valid_i = 1'b0;
  endtask

  task automatic take_r(input int exp_id, input axi_id_remap_pkg::data_t exp_data,
                        input axi_id_remap_pkg::resp_t exp_resp, input logic exp_last);
    int n = 0;
    in_r_ready_i = 1'b1;
    @(negedge clk_i);
    while (!in_r_valid_o) begin
      n++;
      if (n > wait_limit) stop_with_failure("no R beat was returned upstream");
      @(negedge clk_i);
    end
    check("in_r_id", exp_id, in_r_id_o);
    check("in_r_data", exp_data, in_r_data_o);
    check("in_r_resp", exp_resp, in_r_resp_o);
    check("in_r_last", exp_last, in_r_last_o);
    @(posedge clk_i);
    #1 in_r_ready_i = 1'b0;
  endtask

  task automatic issue_read(input int in_id, input int len, output int slot);
    axi_id_remap_pkg::addr_t addr;
    addr = $urandom;
    slot = model_alloc(in_id);
    drive_ar(in_id, addr, len);
    wait_ar_accept();
    take_ar(slot, addr, len);
  endtask

  task automatic return_beat(input int slot, input axi_id_remap_pkg::resp_t resp,
                             input logic last);
    axi_id_remap_pkg::data_t data;
    data = $urandom;
    send_r(slot, data, resp, last);
    take_r(model_id[slot], data, resp, last);
    if (last) model_cnt[slot] = model_cnt[slot] - 1;
  endtask

  task automatic single_read();
    int s;
    cur_test = "single";
    check("out_ar_valid after reset", 0, out_ar_valid_o);
    check("in_r_valid after reset", 0, in_r_valid_o);
    issue_read(37, 0, s);
    check("first slot", 0, s);
    return_beat(s, axi_id_remap_pkg::resp_okay, 1'b1);
  endtask

  task automatic same_id_reuse();
    int s0;
    int s1;
    int s2;
    cur_test = "same_id";
    issue_read(5, 0, s0);
    issue_read(5, 0, s1);
    check("same id shares slot", s0, s1);
    issue_read(9, 0, s2);
    check("new id slot", 1, s2);
    return_beat(s0, axi_id_remap_pkg::resp_okay, 1'b1);
    return_beat(s1, axi_id_remap_pkg::resp_okay, 1'b1);
    return_beat(s2, axi_id_remap_pkg::resp_okay, 1'b1);
  endtask

  task automatic full_table_stall();
    int s;
    axi_id_remap_pkg::addr_t addr;
    cur_test = "table_full";
    for (int i = 0; i < 4; i++) begin
      issue_read(10 + i, 0, s);
      check("fill slot", i, s);
    end
    addr = $urandom;
    drive_ar(14, addr, 0);
    repeat (20) begin
      @(negedge clk_i);
      check("in_ar_ready while full", 0, in_ar_ready_o);
    end
    @(posedge clk_i);
    #1 return_beat(2, axi_id_remap_pkg::resp_okay, 1'b1);
    s = model_alloc(14);
    wait_ar_accept();
    take_ar(s, addr, 0);
    check("reused slot", 2, s);
    for (int i = 0; i < 4; i++) return_beat(i, axi_id_remap_pkg::resp_okay, 1'b1);
  endtask

  task automatic burst_restore();
    int s;
    int s_other;
    int s_late;
    cur_test = "burst";
    issue_read(20, 3, s);
    for (int i = 0; i < 4; i++) begin
      return_beat(s, axi_id_remap_pkg::resp_okay, i == 3);
      if (i == 1) begin
        issue_read(21, 0, s_other);
        check("busy slot avoided", 1, s_other);
      end
    end
    issue_read(22, 0, s_late);
    check("slot freed after last", s, s_late);
    return_beat(s_other, axi_id_remap_pkg::resp_okay, 1'b1);
    return_beat(s_late, axi_id_remap_pkg::resp_okay, 1'b1);
  endtask

  task automatic backpressure_hold();
    int s;
    axi_id_remap_pkg::data_t d0;
    axi_id_remap_pkg::data_t d1;
    cur_test = "backpressure";
    issue_read(30, 1, s);
    d0 = $urandom;
    d1 = $urandom;
    send_r(s, d0, axi_id_remap_pkg::resp_slverr, 1'b0);
    // the second beat queues behind the stalled first one
    out_r_id_i    = axi_id_remap_pkg::out_id_t'(s);
    out_r_data_i  = d1;
    out_r_resp_i  = axi_id_remap_pkg::resp_decerr;
    out_r_last_i  = 1'b1;
    out_r_valid_i = 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      check("in_r_valid held", 1, in_r_valid_o);
      check("in_r_data held", d0, in_r_data_o);
      check("in_r_resp held", axi_id_remap_pkg::resp_slverr, in_r_resp_o);
      check("in_r_id held", 30, in_r_id_o);
      check("out_r_ready dropped", 0, out_r_ready_o);
    end
    @(posedge clk_i);
    #1 take_r(30, d0, axi_id_remap_pkg::resp_slverr, 1'b0);
    out_r_valid_i = 1'b0;
    take_r(30, d1, axi_id_remap_pkg::resp_decerr, 1'b1);
    model_cnt[s] = model_cnt[s] - 1;
  endtask

  initial begin
    seed_val = $urandom(32'h8e5782e3);
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    in_ar_id_i = '0;
    in_ar_addr_i = '0;
    in_ar_len_i = '0;
    in_ar_valid_i = 1'b0;
    in_r_ready_i = 1'b0;
    out_ar_ready_i = 1'b0;
    out_r_id_i = '0;
    out_r_data_i = '0;
    out_r_resp_i = axi_id_remap_pkg::resp_okay;
    out_r_last_i = 1'b0;
    out_r_valid_i = 1'b0;
    for (int i = 0; i < axi_id_remap_pkg::table_size; i++) begin
      model_id[i]  = 0;
      model_cnt[i] = 0;
    end
    repeat (4) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    single_read();
    same_id_reuse();
    full_table_stall();
    burst_restore();
    backpressure_hold();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/axi_id_remap_pkg.sv
verilog/ar_chan_if.sv
verilog/r_chan_if.sv
verilog/id_remap_table.sv
verilog/ar_remap_stage.sv
verilog/r_restore_stage.sv
verilog/axi_id_remap_ports.sv
bench/tb_axi_id_remap.sv

// File: Bender.yml
package:
  name: axi_id_remap

sources:
  - verilog/axi_id_remap_pkg.sv
  - verilog/ar_chan_if.sv
  - verilog/r_chan_if.sv
  - verilog/id_remap_table.sv
  - verilog/ar_remap_stage.sv
  - verilog/r_restore_stage.sv
  - verilog/axi_id_remap_ports.sv
  - target: test
    files:
      - bench/tb_axi_id_remap.sv
